//--- rtl/csr_pkg.sv
package csr_pkg;

  //////////////////////////////
  // CSR types
  //////////////////////////////

  // CSR number as seen on the access port
  typedef logic [11:0] csr_addr_t;

  // One CSR word
  typedef logic [31:0] csr_data_t;

  //////////////////////////////
  // Machine mode addresses
  //////////////////////////////

  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MIE     = 12'h304;
  localparam csr_addr_t CSR_MTVEC   = 12'h305;
  localparam csr_addr_t CSR_MCAUSE  = 12'h342;
  localparam csr_addr_t CSR_MIP     = 12'h344;

  // mstatus fields kept in this core
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;

  // Software, timer, external and the 16 fast lines
  localparam csr_data_t MIE_MASK = 32'hFFFF_0888;

  // Direct mode only, base is word aligned
  localparam csr_data_t MTVEC_MASK  = 32'hFFFF_FFFC;
  localparam csr_data_t MTVEC_RESET = 32'h0000_0000;

endpackage

//--- rtl/ctrl_pkg.sv
package ctrl_pkg;

  //////////////////////////////
  // Controller types
  //////////////////////////////

  // Controller FSM states
  typedef enum logic [2:0] {
    RESET,
    BOOT_WAIT,
    RUN,
    IRQ_TAKE,
    SLEEP
  } ctrl_state_e;

  // Interrupt number, also the mcause code
  typedef logic [4:0] irq_id_t;

  // Raw interrupt lines
  typedef logic [31:0] irq_vec_t;

  // Status broadcast from the controller
  // Read by the CSRs for trap entry
  // Read by the sleep unit for the clock gate
  typedef struct packed {
    logic    irq_ack;
    irq_id_t irq_id;
    logic    sleeping;
  } ctrl_fsm_t;

endpackage

//--- rtl/int_controller.sv
`timescale 1ns/1ps

module int_controller (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  ctrl_pkg::irq_vec_t irq_i,
  input  csr_pkg::csr_data_t mie_i,
  input  logic               m_ie_i,
  output csr_pkg::csr_data_t mip_o,
  output logic               irq_req_o,
  output ctrl_pkg::irq_id_t  irq_id_o,
  output logic               irq_wu_o
);

  import csr_pkg::*;
  import ctrl_pkg::*;

  csr_data_t mip_q;
  csr_data_t pending;

  // Capture on the free running clock
  // Lines without an mie bit never show up in mip
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & MIE_MASK;
    end
  end

  assign mip_o   = mip_q;
  assign pending = mip_q & mie_i;

  // Global enable only gates the request
  assign irq_req_o = m_ie_i && (|pending);

  // Wake-up ignores mstatus.MIE
  assign irq_wu_o  = |pending;

  // Fixed priority, later assignment wins
  // Order from low to high: 7, 3, 11, then fast lines 16 up to 31
  always_comb begin
    irq_id_o = '0;
    if (pending[7]) begin
      irq_id_o = irq_id_t'(7);
    end
    if (pending[3]) begin
      irq_id_o = irq_id_t'(3);
    end
    if (pending[11]) begin
      irq_id_o = irq_id_t'(11);
    end
    for (int i = 16; i < 32; i++) begin
      if (pending[i]) begin
        irq_id_o = irq_id_t'(i);
      end
    end
  end

  // Request carries a wake-up and points at a pending line
  a_req_valid : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    irq_req_o |-> (irq_wu_o && pending[irq_id_o]))
    else $error("interrupt request without a matching pending line");

endmodule

//--- rtl/cs_registers.sv
`timescale 1ns/1ps

module cs_registers (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                csr_we_i,
  input  csr_pkg::csr_addr_t  csr_addr_i,
  input  csr_pkg::csr_data_t  csr_wdata_i,
  output csr_pkg::csr_data_t  csr_rdata_o,
  input  logic                mret_i,
  input  ctrl_pkg::ctrl_fsm_t ctrl_fsm_i,
  input  csr_pkg::csr_data_t  mip_i,
  output csr_pkg::csr_data_t  mie_o,
  output logic                m_ie_o
);

  import csr_pkg::*;
  import ctrl_pkg::*;

  // mstatus, only MIE and MPIE exist
  logic      mstatus_mie_q;
  logic      mstatus_mpie_q;
  csr_data_t mie_q;
  csr_data_t mtvec_q;
  // mcause split into flag and code
  logic      mcause_irq_q;
  irq_id_t   mcause_code_q;

  //////////////////////////////
  // Trap state
  //////////////////////////////

  // Trap entry first, then return, then the access port
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
      mcause_irq_q   <= 1'b0;
      mcause_code_q  <= '0;
    end else if (ctrl_fsm_i.irq_ack) begin
      // Stack the enable and record the cause
      mstatus_mpie_q <= mstatus_mie_q;
      mstatus_mie_q  <= 1'b0;
      mcause_irq_q   <= 1'b1;
      mcause_code_q  <= ctrl_fsm_i.irq_id;
    end else if (mret_i) begin
      // Pop the enable
      mstatus_mie_q  <= mstatus_mpie_q;
      mstatus_mpie_q <= 1'b1;
    end else if (csr_we_i) begin
      case (csr_addr_i)
        CSR_MSTATUS: begin
          mstatus_mie_q  <= csr_wdata_i[MSTATUS_MIE_BIT];
          mstatus_mpie_q <= csr_wdata_i[MSTATUS_MPIE_BIT];
        end
        CSR_MCAUSE: begin
          mcause_irq_q  <= csr_wdata_i[31];
          mcause_code_q <= csr_wdata_i[4:0];
        end
        default: begin
        end
      endcase
    end
  end

  //////////////////////////////
  // Enable and vector
  //////////////////////////////

  // Not touched by trap entry
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mie_q   <= '0;
      mtvec_q <= MTVEC_RESET;
    end else if (csr_we_i) begin
      if (csr_addr_i == CSR_MIE) begin
        mie_q <= csr_wdata_i & MIE_MASK;
      end
      if (csr_addr_i == CSR_MTVEC) begin
        mtvec_q <= csr_wdata_i & MTVEC_MASK;
      end
    end
  end

  // Read mux, unknown addresses give zero
  always_comb begin
    csr_rdata_o = '0;
    case (csr_addr_i)
      CSR_MSTATUS: begin
        csr_rdata_o[MSTATUS_MIE_BIT]  = mstatus_mie_q;
        csr_rdata_o[MSTATUS_MPIE_BIT] = mstatus_mpie_q;
      end
      CSR_MIE:    csr_rdata_o = mie_q;
      CSR_MTVEC:  csr_rdata_o = mtvec_q;
      CSR_MIP:    csr_rdata_o = mip_i;
      CSR_MCAUSE: csr_rdata_o = {mcause_irq_q, 26'b0, mcause_code_q};
      default:    csr_rdata_o = '0;
    endcase
  end

  assign mie_o  = mie_q;
  assign m_ie_o = mstatus_mie_q;

  // Controller acknowledge and trap return never collide
  a_ack_mret : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(ctrl_fsm_i.irq_ack && mret_i))
    else $error("trap return during interrupt acknowledge");

endmodule

//--- rtl/controller_fsm.sv
`timescale 1ns/1ps

module controller_fsm (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                fetch_enable_i,
  input  logic                wfi_i,
  input  logic                irq_req_i,
  input  ctrl_pkg::irq_id_t   irq_id_i,
  input  logic                irq_wu_i,
  output ctrl_pkg::ctrl_fsm_t ctrl_fsm_o
);

  import ctrl_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  irq_id_t     irq_id_q;

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      // One cycle out of reset
      RESET:     state_d = BOOT_WAIT;
      // Hold until fetch is enabled once
      BOOT_WAIT: if (fetch_enable_i) state_d = RUN;
      RUN: begin
        // Interrupt beats wfi
        if (irq_req_i) begin
          state_d = IRQ_TAKE;
        end else if (wfi_i) begin
          state_d = SLEEP;
        end
      end
      // Single acknowledge cycle
      IRQ_TAKE:  state_d = RUN;
      // Only clocked here when the gate is open for wake-up
      SLEEP:     if (irq_wu_i) state_d = RUN;
      default:   state_d = RESET;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= RESET;
      irq_id_q <= '0;
    end else begin
      state_q <= state_d;
      // Latch the winner on the way into IRQ_TAKE
      if (state_q == RUN && irq_req_i) begin
        irq_id_q <= irq_id_i;
      end
    end
  end

  // Status fields straight from the state register
  always_comb begin
    ctrl_fsm_o.irq_ack  = (state_q == IRQ_TAKE);
    ctrl_fsm_o.irq_id   = irq_id_q;
    ctrl_fsm_o.sleeping = (state_q == SLEEP);
  end

  // Acknowledge lasts one cycle
  a_ack_pulse : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ctrl_fsm_o.irq_ack |=> !ctrl_fsm_o.irq_ack)
    else $error("interrupt acknowledge longer than one cycle");

  // Wake-up goes back to RUN before any acknowledge
  a_no_ack_sleep : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ctrl_fsm_o.sleeping |=> !ctrl_fsm_o.irq_ack)
    else $error("interrupt acknowledged straight out of sleep");

endmodule

//--- rtl/sleep_unit.sv
`timescale 1ns/1ps

module sleep_unit (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                fetch_enable_i,
  input  ctrl_pkg::ctrl_fsm_t ctrl_fsm_i,
  input  logic                irq_wu_i,
  output logic                clk_gated_o,
  output logic                fetch_enable_o,
  output logic                core_sleep_o
);

  logic fetch_enable_q;
  logic core_sleep_q;
  logic clk_en;
  logic clk_en_lat;

  // Sticky fetch enable and sleep status, both on the free clock
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fetch_enable_q <= 1'b0;
      core_sleep_q   <= 1'b0;
    end else begin
      fetch_enable_q <= fetch_enable_q | fetch_enable_i;
      // One cycle behind the controller state
      core_sleep_q   <= ctrl_fsm_i.sleeping;
    end
  end

  assign fetch_enable_o = fetch_enable_q;
  assign core_sleep_o   = core_sleep_q;

  //////////////////////////////
  // Clock gate
  //////////////////////////////

  // Closed only while asleep with nothing to wake on
  assign clk_en = !(ctrl_fsm_i.sleeping && !irq_wu_i);

  // Transparent in the low phase, glitch free
  always_latch begin
    if (!clk_i) begin
      clk_en_lat <= clk_en;
    end
  end

  assign clk_gated_o = clk_i & clk_en_lat;

  // Sleep needs the core to have been started
  a_sleep_started : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !fetch_enable_o |-> !core_sleep_o)
    else $error("core asleep before fetch was enabled");

endmodule

//--- rtl/core_irq_top.sv
`timescale 1ns/1ps

module core_irq_top (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               fetch_enable_i,
  input  ctrl_pkg::irq_vec_t irq_i,
  input  logic               wfi_i,
  input  logic               mret_i,
  input  logic               csr_we_i,
  input  csr_pkg::csr_addr_t csr_addr_i,
  input  csr_pkg::csr_data_t csr_wdata_i,
  output csr_pkg::csr_data_t csr_rdata_o,
  output logic               irq_ack_o,
  output ctrl_pkg::irq_id_t  irq_id_o,
  output logic               core_sleep_o
);

  import csr_pkg::*;
  import ctrl_pkg::*;

  // Gated core clock
  logic      clk;
  logic      fetch_enable;
  // Interrupt controller to controller
  logic      irq_req;
  irq_id_t   irq_id;
  logic      irq_wu;
  // CSR side of the interrupt path
  csr_data_t mip;
  csr_data_t mie;
  logic      m_ie;
  ctrl_fsm_t ctrl_fsm;

  assign irq_ack_o = ctrl_fsm.irq_ack;
  assign irq_id_o  = ctrl_fsm.irq_id;

  //////////////////////////////
  // Clock and sleep
  //////////////////////////////

  sleep_unit sleep_unit_i (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .fetch_enable_i ( fetch_enable_i ),
    .ctrl_fsm_i     ( ctrl_fsm       ),
    .irq_wu_i       ( irq_wu         ),
    .clk_gated_o    ( clk            ),
    .fetch_enable_o ( fetch_enable   ),
    .core_sleep_o   ( core_sleep_o   )
  );

  // Ungated, so lines are seen while asleep
  int_controller int_controller_i (
    .clk_i     ( clk_i    ),
    .arst_n_i  ( arst_n_i ),
    .irq_i     ( irq_i    ),
    .mie_i     ( mie      ),
    .m_ie_i    ( m_ie     ),
    .mip_o     ( mip      ),
    .irq_req_o ( irq_req  ),
    .irq_id_o  ( irq_id   ),
    .irq_wu_o  ( irq_wu   )
  );

  //////////////////////////////
  // CSRs and controller
  //////////////////////////////

  cs_registers cs_registers_i (
    .clk_i       ( clk         ),
    .arst_n_i    ( arst_n_i    ),
    .csr_we_i    ( csr_we_i    ),
    .csr_addr_i  ( csr_addr_i  ),
    .csr_wdata_i ( csr_wdata_i ),
    .csr_rdata_o ( csr_rdata_o ),
    .mret_i      ( mret_i      ),
    .ctrl_fsm_i  ( ctrl_fsm    ),
    .mip_i       ( mip         ),
    .mie_o       ( mie         ),
    .m_ie_o      ( m_ie        )
  );

  controller_fsm controller_fsm_i (
    .clk_i          ( clk          ),
    .arst_n_i       ( arst_n_i     ),
    .fetch_enable_i ( fetch_enable ),
    .wfi_i          ( wfi_i        ),
    .irq_req_i      ( irq_req      ),
    .irq_id_i       ( irq_id       ),
    .irq_wu_i       ( irq_wu       ),
    .ctrl_fsm_o     ( ctrl_fsm     )
  );

endmodule

//--- bench/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  // 4 ns period, free running
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Reset held over the first 5 rising edges
  initial begin
    arst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule

//--- bench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
  input  logic               clk_i,
  input  logic               irq_ack_i,
  input  ctrl_pkg::irq_id_t  irq_id_i,
  input  logic               core_sleep_i,
  input  csr_pkg::csr_data_t csr_rdata_i,
  output int                 ack_count_o,
  output int                 tests_o,
  output int                 failed_o,
  output int                 errors_o
);

  // Errors in the test that is running
  int test_errors;

  initial begin
    ack_count_o = 0;
    tests_o     = 0;
    failed_o    = 0;
    errors_o    = 0;
    test_errors = 0;
  end

  // Every acknowledge pulse, counted at the edge that ends it
  always @(posedge clk_i) begin
    if (irq_ack_i === 1'b1) begin
      ack_count_o <= ack_count_o + 1;
    end
  end

  //////////////////////////////
  // Compare helpers
  //////////////////////////////

  task automatic check_eq(input string name, input string what,
                          input logic [31:0] exp_val, input logic [31:0] act_val);
    if (act_val !== exp_val) begin
      $display("CHECK FAILED %s: %s expected 0x%08h, actual 0x%08h",
               name, what, exp_val, act_val);
      test_errors = test_errors + 1;
      errors_o    = errors_o + 1;
    end
  endtask

  // Failures that are not a wrong value
  task automatic report_problem(input string name, input string what);
    $display("ERROR %s: %s", name, what);
    test_errors = test_errors + 1;
    errors_o    = errors_o + 1;
  endtask

  // Acknowledge and id as they stand now
  task automatic sample_ack(input string name, input logic exp_ack,
                            input ctrl_pkg::irq_id_t exp_id);
    check_eq(name, "irq_ack_o", exp_ack, irq_ack_i);
    if (exp_ack) begin
      check_eq(name, "irq_id_o", exp_id, irq_id_i);
    end
  endtask

  // Called right after the lines change on an edge
  // Ack must be low after the first edge, valid after the second
  task automatic check_ack(input string name, input logic exp_ack,
                           input ctrl_pkg::irq_id_t exp_id);
    @(posedge clk_i);
    @(negedge clk_i);
    check_eq(name, "irq_ack_o after first edge", 1'b0, irq_ack_i);
    @(posedge clk_i);
    @(negedge clk_i);
    sample_ack(name, exp_ack, exp_id);
  endtask

  task automatic check_csr(input string name, input string what,
                           input csr_pkg::csr_data_t exp_val);
    check_eq(name, what, exp_val, csr_rdata_i);
  endtask

  task automatic check_sleep(input string name, input logic exp_val);
    check_eq(name, "core_sleep_o", exp_val, core_sleep_i);
  endtask

  // One result line per test
  task automatic test_done(input string name);
    tests_o = tests_o + 1;
    if (test_errors == 0) begin
      $display("[%0t] %s passed", $time, name);
    end else begin
      $display("[%0t] %s failed with %0d errors", $time, name, test_errors);
      failed_o = failed_o + 1;
    end
    test_errors = 0;
  endtask

endmodule

//--- bench/tb_core_irq.sv
`timescale 1ns/1ps

module tb_core_irq;

  import csr_pkg::*;
  import ctrl_pkg::*;

  // One interrupt test, the name sits in its own array
  typedef struct packed {
    logic      fetch;
    csr_data_t mie;
    csr_data_t mstatus;
    irq_vec_t  vec;
    logic      exp_ack;
    irq_id_t   exp_id;
    csr_data_t exp_mcause;
  } row_t;

  logic      clk;
  logic      arst_n;
  logic      fetch_enable;
  irq_vec_t  irq;
  logic      wfi;
  logic      mret;
  logic      csr_we;
  csr_addr_t csr_addr;
  csr_data_t csr_wdata;
  csr_data_t csr_rdata;
  logic      irq_ack;
  irq_id_t   irq_id;
  logic      core_sleep;
  int        ack_count;
  int        tests;
  int        failed;
  int        errors;
  row_t      rows [10];
  string     names [10];
  int        num_rows;
  logic [31:0] lfsr;

  tb_clk_gen clk_gen_i (
    .clk_o    ( clk    ),
    .arst_n_o ( arst_n )
  );

  core_irq_top dut_i (
    .clk_i          ( clk          ),
    .arst_n_i       ( arst_n       ),
    .fetch_enable_i ( fetch_enable ),
    .irq_i          ( irq          ),
    .wfi_i          ( wfi          ),
    .mret_i         ( mret         ),
    .csr_we_i       ( csr_we       ),
    .csr_addr_i     ( csr_addr     ),
    .csr_wdata_i    ( csr_wdata    ),
    .csr_rdata_o    ( csr_rdata    ),
    .irq_ack_o      ( irq_ack      ),
    .irq_id_o       ( irq_id       ),
    .core_sleep_o   ( core_sleep   )
  );

  tb_checker chk_i (
    .clk_i        ( clk        ),
    .irq_ack_i    ( irq_ack    ),
    .irq_id_i     ( irq_id     ),
    .core_sleep_i ( core_sleep ),
    .csr_rdata_i  ( csr_rdata  ),
    .ack_count_o  ( ack_count  ),
    .tests_o      ( tests      ),
    .failed_o     ( failed     ),
    .errors_o     ( errors     )
  );

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_vector(output irq_vec_t vec);
    vec = '0;
    for (int b = 0; b < 32; b++) begin
      lfsr = lfsr_next(lfsr);
      vec  = {vec[30:0], lfsr[0]};
    end
  endtask

  // Highest fast line first, then external, software, timer
  function automatic irq_id_t winner_id(input logic [31:0] pend);
    for (int i = 31; i >= 16; i--) begin
      if (pend[i]) return irq_id_t'(i);
    end
    if (pend[11]) return irq_id_t'(11);
    if (pend[3]) return irq_id_t'(3);
    if (pend[7]) return irq_id_t'(7);
    return '0;
  endfunction

  //////////////////////////////
  // Bus helpers
  //////////////////////////////

  task automatic csr_write(input csr_addr_t addr, input csr_data_t data);
    @(posedge clk);
    csr_we    <= 1'b1;
    csr_addr  <= addr;
    csr_wdata <= data;
    @(posedge clk);
    csr_we    <= 1'b0;
  endtask

  // Combinational read, sampled mid cycle
  task automatic csr_read_check(input string name, input string what,
                                input csr_addr_t addr, input csr_data_t exp_val);
    @(posedge clk);
    csr_addr <= addr;
    @(negedge clk);
    chk_i.check_csr(name, what, exp_val);
  endtask

  task automatic set_lines(input irq_vec_t vec);
    @(posedge clk);
    irq <= vec;
  endtask

  task automatic wait_sleep(input string name, input logic level);
    int n;
    for (n = 0; n < 20 && core_sleep !== level; n++) begin
      @(negedge clk);
    end
    if (core_sleep !== level) begin
      chk_i.report_problem(name,
        $sformatf("core_sleep_o did not reach %0b within 20 cycles", level));
    end
  endtask

  task automatic add_row(input string name, input logic fetch, input csr_data_t mie,
                         input csr_data_t mstatus, input irq_vec_t vec, input logic ack,
                         input irq_id_t id, input csr_data_t mcause);
    names[num_rows] = name;
    rows[num_rows]  = {fetch, mie, mstatus, vec, ack, id, mcause};
    num_rows        = num_rows + 1;
  endtask

  task automatic load_table();
    num_rows = 0;
    // name, fetch, mie, mstatus, lines (0 from LFSR), ack, id, mcause
    add_row("no_fetch", 1'b0, 32'h0001_0000, 32'h8, 32'h0001_0000, 1'b0, 5'd0, 32'h0);
    add_row("fetch_start", 1'b1, 32'h0001_0000, 32'h8, 32'h0001_0000, 1'b1, 5'd16, 32'h8000_0010);
    add_row("prio_fast", 1'b1, 32'hFFFF_FFFF, 32'h8, 32'h0042_0888, 1'b1, 5'd22, 32'h8000_0016);
    add_row("prio_ext", 1'b1, 32'hFFFF_FFFF, 32'h8, 32'h0000_0888, 1'b1, 5'd11, 32'h8000_000B);
    add_row("prio_sw", 1'b1, 32'hFFFF_FFFF, 32'h8, 32'h0000_0088, 1'b1, 5'd3, 32'h8000_0003);
    add_row("mie_masked", 1'b1, 32'h0000_0080, 32'h8, 32'h0001_0008, 1'b0, 5'd0, 32'h0);
    add_row("mie_global", 1'b1, 32'hFFFF_FFFF, 32'h0, 32'h8000_0000, 1'b0, 5'd0, 32'h0);
    add_row("lfsr_all", 1'b1, 32'hFFFF_FFFF, 32'h8, 32'h0, 1'b0, 5'd0, 32'h0);
    add_row("lfsr_std", 1'b1, 32'h0000_0888, 32'h8, 32'h0, 1'b0, 5'd0, 32'h0);
    add_row("lfsr_all_b", 1'b1, 32'hFFFF_FFFF, 32'h8, 32'h0, 1'b0, 5'd0, 32'h0);
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic csr_test();
    string name;
    name = "csr_access";
    csr_write(CSR_MIE, 32'hFFFF_FFFF);
    csr_read_check(name, "mie", CSR_MIE, 32'hFFFF_0888);
    csr_write(CSR_MTVEC, 32'h1234_5677);
    csr_read_check(name, "mtvec", CSR_MTVEC, 32'h1234_5674);
    csr_read_check(name, "unknown address", 12'h7C0, 32'h0);
    // mip follows the lines one edge later
    @(posedge clk);
    irq      <= 32'h8001_0808;
    csr_addr <= CSR_MIP;
    @(negedge clk);
    chk_i.check_csr(name, "mip before capture", 32'h0);
    @(negedge clk);
    chk_i.check_csr(name, "mip after capture", 32'h8001_0808);
    // Read only, a write leaves it alone
    csr_write(CSR_MIP, 32'h0);
    @(negedge clk);
    chk_i.check_csr(name, "mip after write", 32'h8001_0808);
    csr_write(CSR_MIE, 32'h0);
    set_lines('0);
    chk_i.test_done(name);
  endtask

  task automatic run_row(input int r);
    row_t      row;
    irq_vec_t  vec;
    logic      exp_ack;
    irq_id_t   exp_id;
    csr_data_t exp_mcause;
    row        = rows[r];
    vec        = row.vec;
    exp_ack    = row.exp_ack;
    exp_id     = row.exp_id;
    exp_mcause = row.exp_mcause;
    set_lines('0);
    if (row.fetch) begin
      @(posedge clk);
      fetch_enable <= 1'b1;
      @(posedge clk);
      fetch_enable <= 1'b0;
      // Sticky register, then BOOT_WAIT into RUN
      repeat (2) @(posedge clk);
    end
    csr_write(CSR_MIE, row.mie);
    csr_write(CSR_MSTATUS, row.mstatus);
    // Random rows take their expectation from the priority rule
    if (vec == '0) begin
      draw_vector(vec);
      exp_id     = winner_id(vec & row.mie & 32'hFFFF_0888);
      exp_ack    = row.fetch && row.mstatus[MSTATUS_MIE_BIT] &&
                   (|(vec & row.mie & 32'hFFFF_0888));
      exp_mcause = {1'b1, 26'b0, exp_id};
    end
    set_lines(vec);
    chk_i.check_ack(names[r], exp_ack, exp_id);
    if (exp_ack) begin
      // Trap entry stacks MIE into MPIE
      csr_read_check(names[r], "mstatus", CSR_MSTATUS, 32'h0000_0080);
      csr_read_check(names[r], "mcause", CSR_MCAUSE, exp_mcause);
    end
    chk_i.test_done(names[r]);
  endtask

  task automatic trap_test();
    string name;
    int    acks;
    name = "trap_return";
    set_lines('0);
    csr_write(CSR_MIE, 32'hFFFF_FFFF);
    csr_write(CSR_MSTATUS, 32'h0000_0008);
    set_lines(32'h0000_0800);
    chk_i.check_ack(name, 1'b1, 5'd11);
    // Second line held while the trap keeps MIE clear
    set_lines(32'h0010_0800);
    @(negedge clk);
    acks = ack_count;
    repeat (5) @(negedge clk);
    chk_i.check_eq(name, "acknowledges while MIE clear", acks, ack_count);
    csr_read_check(name, "mstatus in trap", CSR_MSTATUS, 32'h0000_0080);
    @(posedge clk);
    mret <= 1'b1;
    @(posedge clk);
    mret <= 1'b0;
    @(negedge clk);
    chk_i.check_csr(name, "mstatus after mret", 32'h0000_0088);
    // Fast line 20 beats line 11
    @(posedge clk);
    @(negedge clk);
    chk_i.sample_ack(name, 1'b1, 5'd20);
    chk_i.test_done(name);
  endtask

  task automatic sleep_test();
    string name;
    int    acks;
    name = "sleep_wake";
    set_lines('0);
    csr_write(CSR_MIE, 32'h0001_0000);
    csr_write(CSR_MSTATUS, 32'h0);
    @(posedge clk);
    wfi <= 1'b1;
    @(posedge clk);
    wfi <= 1'b0;
    wait_sleep(name, 1'b1);
    // Line 17 has no mie bit, no wake-up
    set_lines(32'h0002_0000);
    repeat (4) @(negedge clk);
    chk_i.check_sleep(name, 1'b1);
    acks = ack_count;
    // Line 16 wakes even with MIE clear
    set_lines(32'h0003_0000);
    wait_sleep(name, 1'b0);
    repeat (3) @(negedge clk);
    chk_i.check_eq(name, "acknowledges on wake-up", acks, ack_count);
    set_lines('0);
    chk_i.test_done(name);
  endtask

  initial begin
    fetch_enable = 1'b0;
    irq          = '0;
    wfi          = 1'b0;
    mret         = 1'b0;
    csr_we       = 1'b0;
    csr_addr     = '0;
    csr_wdata    = '0;
    lfsr         = 32'hb2a3c65b;
    load_table();
    for (int n = 0; n < 20 && arst_n !== 1'b1; n++) begin
      @(posedge clk);
    end
    if (arst_n !== 1'b1) begin
      chk_i.report_problem("reset", "reset did not release within 20 cycles");
    end
    csr_test();
    for (int r = 0; r < num_rows; r++) begin
      run_row(r);
    end
    trap_test();
    sleep_test();
    $display("Done: %0d tests, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- core_irq.f
rtl/csr_pkg.sv
rtl/ctrl_pkg.sv
rtl/int_controller.sv
rtl/cs_registers.sv
rtl/controller_fsm.sv
rtl/sleep_unit.sv
rtl/core_irq_top.sv
bench/tb_clk_gen.sv
bench/tb_checker.sv
bench/tb_core_irq.sv
